//--- Makefile
VERILATOR  ?= verilator
TOP        := fe_tb
FILELIST   := sim.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/fe_btb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch target buffer
// direct mapped, tag + target per entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fe_btb (
  input  wire               clk,
  input  wire               rst,
  input  fe_types_pkg::pc_t pc,
  output logic              hit,
  output fe_types_pkg::pc_t target,
  fe_upd_if.btb             upd
);

  import fe_cfg_pkg::*;
  import fe_types_pkg::*;

  logic [ENTRIES-1:0] valid;
  tag_t               tag_mem [ENTRIES];
  pc_t                tgt_mem [ENTRIES];

  idx_t rd_idx;
  idx_t wr_idx;
  tag_t rd_tag;
  tag_t wr_tag;
  logic wr_en;

  assign rd_idx = pc[IDX_LSB +: IDX_W];
  assign rd_tag = pc[TAG_LSB +: TAG_W];
  assign wr_idx = upd.pc[IDX_LSB +: IDX_W];
  assign wr_tag = upd.pc[TAG_LSB +: TAG_W];
  assign wr_en  = upd.we && upd.taken; // only taken branches installed

  // lookup, zero cycle
  assign hit    = valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
  assign target = tgt_mem[rd_idx];

  always_ff @(posedge clk) begin
    if (rst)
      valid <= '0;
    else if (wr_en)
      valid[wr_idx] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_idx] <= wr_tag;
      tgt_mem[wr_idx] <= upd.target;
    end
  end

endmodule

`default_nettype wire

//--- logic/fe_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end configuration
// sizes, reset address, index bit fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fe_cfg_pkg;

  localparam int PC_W        = 32;
  localparam int FETCH_BYTES = 16; // one fetch block

  // table and btb index from pc[9:4]
  localparam int IDX_W   = 6;
  localparam int IDX_LSB = 4;
  localparam int ENTRIES = 1 << IDX_W;

  // btb tag is everything above the index
  localparam int TAG_LSB = IDX_LSB + IDX_W;
  localparam int TAG_W   = PC_W - TAG_LSB;

  localparam int HIST_W = 12;

  // history bits mixed into each table index
  localparam int HIST_A  = 2;
  localparam int HIST_B  = 6;
  localparam int HIST_C  = 12;
  localparam int NUM_TBL = 3;
  localparam int TBL_HIST_LEN [NUM_TBL] = '{HIST_A, HIST_B, HIST_C};

  localparam logic [PC_W-1:0] RESET_PC = 32'h0000_1000;

endpackage

`default_nettype wire

//--- logic/fe_dir_pred.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// direction predictor
// three 1-bit tables, xor combined
// rotating flip on mispredict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fe_dir_pred (
  input  wire                 clk,
  input  wire                 rst,
  input  fe_types_pkg::pc_t   pc,
  input  fe_types_pkg::hist_t hist,
  output logic                pred_taken,
  fe_upd_if.pred              upd
);

  import fe_cfg_pkg::*;
  import fe_types_pkg::*;

  logic [ENTRIES-1:0] tbl [NUM_TBL];
  tbl_sel_t           sel;

  idx_t               rd_idx [NUM_TBL];
  idx_t               wr_idx [NUM_TBL];
  logic [NUM_TBL-1:0] rd_bit;

  // xor-fold the low len history bits down to an index
  function automatic idx_t fold_hist(hist_t h, int len);
    idx_t r;
    r = '0;
    for (int i = 0; i < HIST_W; i++) begin
      if (i < len)
        r[i % IDX_W] = r[i % IDX_W] ^ h[i];
    end
    return r;
  endfunction

  always_comb begin
    for (int t = 0; t < NUM_TBL; t++) begin
      rd_idx[t] = pc[IDX_LSB +: IDX_W] ^ fold_hist(hist, TBL_HIST_LEN[t]);
      wr_idx[t] = upd.pc[IDX_LSB +: IDX_W] ^ fold_hist(upd.hist, TBL_HIST_LEN[t]);
      rd_bit[t] = tbl[t][rd_idx[t]];
    end
  end

  assign pred_taken = ^rd_bit;

  // any single flip inverts the xor
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < NUM_TBL; t++)
        tbl[t] <= '0; // all not taken
      sel <= TBL_A;
    end else if (upd.we && upd.mispred) begin
      tbl[sel][wr_idx[sel]] <= ~tbl[sel][wr_idx[sel]];
      case (sel)
        TBL_A:   sel <= TBL_B;
        TBL_B:   sel <= TBL_C;
        default: sel <= TBL_A;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/fe_next_pc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch pointer and global history
// next pc choice, retire update FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fe_next_pc (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 fetch_ready,
  input  wire                 upd_req,
  input  wire                 upd_taken,
  input  wire                 upd_mispred,
  input  wire                 pred_taken,
  input  wire                 btb_hit,
  input  fe_types_pkg::pc_t   upd_pc,
  input  fe_types_pkg::pc_t   upd_target,
  input  fe_types_pkg::pc_t   btb_target,
  input  fe_types_pkg::hist_t upd_hist,
  output logic                fetch_valid,
  output logic                upd_ack,
  output fe_types_pkg::pc_t   fetch_pc,
  output fe_types_pkg::hist_t fetch_hist,
  fe_upd_if.src               upd
);

  import fe_cfg_pkg::*;
  import fe_types_pkg::*;

  upd_state_t state;
  upd_state_t state_nxt;

  logic  redirect;
  logic  advance;
  pc_t   redir_pc;
  hist_t redir_hist;
  pc_t   pc_nxt;
  hist_t hist_nxt;

  // request seen in idle, redirect lands with the ack edge
  assign redirect   = (state == IDLE) && upd_req && upd_mispred;
  assign advance    = fetch_valid && fetch_ready;
  assign redir_pc   = upd_taken ? upd_target : upd_pc + pc_t'(FETCH_BYTES);
  assign redir_hist = {upd_hist[HIST_W-2:0], upd_taken}; // actual outcome

  always_comb begin
    pc_nxt   = fetch_pc;
    hist_nxt = fetch_hist;
    if (redirect) begin
      pc_nxt   = redir_pc;
      hist_nxt = redir_hist;
    end else if (advance) begin
      if (btb_hit && pred_taken)
        pc_nxt = btb_target;
      else
        pc_nxt = fetch_pc + pc_t'(FETCH_BYTES);
      if (btb_hit)
        hist_nxt = {fetch_hist[HIST_W-2:0], pred_taken}; // known branch only
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc    <= RESET_PC;
      fetch_hist  <= '0;
      fetch_valid <= 1'b0;
    end else begin
      fetch_pc    <= pc_nxt;
      fetch_hist  <= hist_nxt;
      fetch_valid <= 1'b1;
    end
  end

  // four-phase handshake
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:      if (upd_req) state_nxt = APPLY;
      APPLY:     state_nxt = upd_req ? WAIT_DROP : IDLE;
      WAIT_DROP: if (!upd_req) state_nxt = IDLE;
      default:   state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  assign upd_ack = (state != IDLE);

  // data is held stable by the source while req is high
  assign upd.we      = (state == APPLY);
  assign upd.pc      = upd_pc;
  assign upd.target  = upd_target;
  assign upd.hist    = upd_hist;
  assign upd.taken   = upd_taken;
  assign upd.mispred = upd_mispred;

endmodule

`default_nettype wire

//--- logic/fe_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end top
// next pc unit, predictor, btb
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fe_top (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 fetch_ready,
  input  wire                 upd_req,
  input  wire                 upd_taken,
  input  wire                 upd_mispred,
  input  fe_types_pkg::pc_t   upd_pc,
  input  fe_types_pkg::pc_t   upd_target,
  input  fe_types_pkg::hist_t upd_hist,
  output logic                fetch_valid,
  output logic                upd_ack,
  output fe_types_pkg::pc_t   fetch_pc,
  output fe_types_pkg::hist_t fetch_hist
);

  import fe_types_pkg::*;

  logic pred_taken;
  logic btb_hit;
  pc_t  btb_target;

  fe_upd_if upd_bus ();

  fe_next_pc u_next_pc (
    .clk         (clk),
    .rst         (rst),
    .fetch_ready (fetch_ready),
    .upd_req     (upd_req),
    .upd_taken   (upd_taken),
    .upd_mispred (upd_mispred),
    .pred_taken  (pred_taken),
    .btb_hit     (btb_hit),
    .upd_pc      (upd_pc),
    .upd_target  (upd_target),
    .btb_target  (btb_target),
    .upd_hist    (upd_hist),
    .fetch_valid (fetch_valid),
    .upd_ack     (upd_ack),
    .fetch_pc    (fetch_pc),
    .fetch_hist  (fetch_hist),
    .upd         (upd_bus.src)
  );

  // both lookups see the same fetch pc
  fe_dir_pred u_dir_pred (
    .clk        (clk),
    .rst        (rst),
    .pc         (fetch_pc),
    .hist       (fetch_hist),
    .pred_taken (pred_taken),
    .upd        (upd_bus.pred)
  );

  fe_btb u_btb (
    .clk    (clk),
    .rst    (rst),
    .pc     (fetch_pc),
    .hit    (btb_hit),
    .target (btb_target),
    .upd    (upd_bus.btb)
  );

endmodule

`default_nettype wire

//--- logic/fe_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end types
// pc, history, index and tag vectors
// handshake FSM and table selector enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fe_types_pkg;

  import fe_cfg_pkg::*;

  typedef logic [PC_W-1:0]   pc_t;
  typedef logic [HIST_W-1:0] hist_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [TAG_W-1:0]  tag_t;

  // retire update handshake
  typedef enum logic [1:0] {
    IDLE,
    APPLY,     // ack high, write strobe
    WAIT_DROP  // ack held until req falls
  } upd_state_t;

  // next table to flip on a mispredict
  typedef enum logic [1:0] {
    TBL_A,
    TBL_B,
    TBL_C
  } tbl_sel_t;

endpackage

`default_nettype wire

//--- logic/fe_upd_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// retire update bus
// one write to predictor and btb
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

interface fe_upd_if;

  import fe_types_pkg::*;

  logic  we;      // single cycle strobe
  pc_t   pc;      // pc of the branch block
  pc_t   target;
  hist_t hist;    // history seen at predict time
  logic  taken;   // actual outcome
  logic  mispred;

  modport src (
    output we, pc, target, hist, taken, mispred
  );

  modport pred (
    input we, pc, hist, mispred
  );

  modport btb (
    input we, pc, target, taken
  );

endinterface

`default_nettype wire

//--- sim.f
logic/fe_cfg_pkg.sv
logic/fe_types_pkg.sv
logic/fe_upd_if.sv
logic/fe_dir_pred.sv
logic/fe_btb.sv
logic/fe_next_pc.sv
logic/fe_top.sv
tests/fe_clkgen.sv
tests/fe_assert.sv
tests/fe_tb.sv

//--- tests/fe_assert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks bound into fe_top
// reset state, handshake order, redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fe_assert (
  input wire                 clk,
  input wire                 rst,
  input wire                 fetch_ready,
  input wire                 upd_req,
  input wire                 upd_taken,
  input wire                 upd_mispred,
  input fe_types_pkg::pc_t   upd_pc,
  input fe_types_pkg::pc_t   upd_target,
  input wire                 fetch_valid,
  input wire                 upd_ack,
  input fe_types_pkg::pc_t   fetch_pc,
  input fe_types_pkg::hist_t fetch_hist,
  input wire                 btb_hit
);

  timeunit 1ns;
  timeprecision 100ps;

  import fe_cfg_pkg::*;
  import fe_types_pkg::*;

  int unsigned fail_cnt = 0;
  logic        redir;

  assign redir = upd_req && !upd_ack && upd_mispred; // request seen while idle

  a_reset_state: assert property (@(posedge clk)
    $fell(rst) |=> fetch_valid && fetch_pc == RESET_PC && !upd_ack)
    else begin $error("state after reset is wrong"); fail_cnt++; end

  a_ack_drops: assert property (@(posedge clk) disable iff (rst)
    !upd_req |=> !upd_ack)
    else begin $error("upd_ack high without upd_req"); fail_cnt++; end

  a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
    $rose(upd_ack) |-> $past(upd_req))
    else begin $error("upd_ack rose before upd_req"); fail_cnt++; end

  a_ack_rises: assert property (@(posedge clk) disable iff (rst)
    upd_req && !upd_ack |=> upd_ack)
    else begin $error("upd_ack did not answer upd_req"); fail_cnt++; end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    fetch_valid && !fetch_ready && !redir |=> $stable(fetch_pc) && $stable(fetch_hist))
    else begin $error("fetch moved under back-pressure"); fail_cnt++; end

  // sequential fetch with no btb entry
  a_seq: assert property (@(posedge clk) disable iff (rst)
    fetch_valid && fetch_ready && !btb_hit && !redir
    |=> fetch_pc == $past(fetch_pc) + pc_t'(FETCH_BYTES))
    else begin $error("sequential fetch did not add 16"); fail_cnt++; end

  a_redir_taken: assert property (@(posedge clk) disable iff (rst)
    redir && upd_taken |=> fetch_pc == $past(upd_target))
    else begin $error("taken redirect missed target"); fail_cnt++; end

  a_redir_fall: assert property (@(posedge clk) disable iff (rst)
    redir && !upd_taken |=> fetch_pc == $past(upd_pc) + pc_t'(FETCH_BYTES))
    else begin $error("not-taken redirect missed fall-through"); fail_cnt++; end

endmodule

bind fe_top fe_assert u_fe_assert (
  .clk         (clk),
  .rst         (rst),
  .fetch_ready (fetch_ready),
  .upd_req     (upd_req),
  .upd_taken   (upd_taken),
  .upd_mispred (upd_mispred),
  .upd_pc      (upd_pc),
  .upd_target  (upd_target),
  .fetch_valid (fetch_valid),
  .upd_ack     (upd_ack),
  .fetch_pc    (fetch_pc),
  .fetch_hist  (fetch_hist),
  .btb_hit     (btb_hit)
);

`default_nettype wire

//--- tests/fe_clkgen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clock and reset generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fe_clkgen (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tests/fe_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch front end testbench
// sequential fetch, handshake, redirects
// btb install and prediction flips
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fe_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import fe_cfg_pkg::*;
  import fe_types_pkg::*;

  localparam int SEQ_CYCLES = 48;
  localparam int MAX_CYCLES = 2000; // tests need about 120 cycles

  logic  clk, rst;
  logic  fetch_ready, upd_req, upd_taken, upd_mispred;
  pc_t   upd_pc, upd_target, fetch_pc, exp_pc;
  hist_t upd_hist, fetch_hist;
  logic  fetch_valid, upd_ack, last_ready;

  logic [31:0] rnd = 32'd13;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          tests = 0;
  int          err_mark;
  int          total_err;

  localparam pc_t   P_BR = 32'h0000_1400;
  localparam pc_t   T_BR = 32'h0000_1800;
  localparam hist_t H_BR = 12'h5a2;

  fe_clkgen u_clkgen (.clk(clk), .rst(rst));

  fe_top DUT (
    .clk(clk), .rst(rst), .fetch_ready(fetch_ready),
    .upd_req(upd_req), .upd_taken(upd_taken), .upd_mispred(upd_mispred),
    .upd_pc(upd_pc), .upd_target(upd_target), .upd_hist(upd_hist),
    .fetch_valid(fetch_valid), .upd_ack(upd_ack),
    .fetch_pc(fetch_pc), .fetch_hist(fetch_hist)
  );

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "errors");
    err_mark = errors;
  endtask

  // full four-phase update, always a mispredict
  task automatic send_update(pc_t pc, pc_t target, hist_t hist, logic taken, int hold);
    pc_t exp;
    exp = taken ? target : pc + pc_t'(FETCH_BYTES);
    @(negedge clk);
    upd_pc      = pc;
    upd_target  = target;
    upd_hist    = hist;
    upd_taken   = taken;
    upd_mispred = 1'b1;
    upd_req     = 1'b1;
    @(negedge clk);
    while (!upd_ack) @(negedge clk);
    compare_value("fetch_pc", fetch_pc, exp); // redirect lands with ack
    compare_value("fetch_hist", 32'(fetch_hist), 32'({hist[HIST_W-2:0], taken}));
    repeat (hold) @(negedge clk); // req kept high past the ack
    upd_req = 1'b0;
    @(negedge clk);
    while (upd_ack) @(negedge clk);
    upd_mispred = 1'b0;
  endtask

  task automatic accept_fetch();
    @(negedge clk);
    fetch_ready = 1'b1;
    @(negedge clk);
    fetch_ready = 1'b0;
  endtask

  // steer fetch to P_BR with history H_BR by a not-taken redirect
  task automatic visit_branch();
    send_update(P_BR - pc_t'(FETCH_BYTES), 32'h0, H_BR >> 1, 1'b0, 0);
    compare_value("fetch_pc", fetch_pc, P_BR);
    compare_value("fetch_hist", 32'(fetch_hist), 32'(H_BR));
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run went past %0d cycles", MAX_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    fetch_ready = 1'b0;
    upd_req     = 1'b0;
    upd_taken   = 1'b0;
    upd_mispred = 1'b0;
    upd_pc      = '0;
    upd_target  = '0;
    upd_hist    = '0;
    err_mark    = 0;

    @(negedge clk);
    while (rst || !fetch_valid) @(negedge clk);
    compare_value("fetch_pc", fetch_pc, RESET_PC);
    compare_value("upd_ack", 32'(upd_ack), 32'd0);

    // random back-pressure, no btb entries yet
    exp_pc = RESET_PC;
    for (int i = 0; i < SEQ_CYCLES; i++) begin
      rnd = xorshift(rnd);
      fetch_ready = rnd[0];
      last_ready = rnd[0];
      @(negedge clk);
      if (last_ready)
        exp_pc = exp_pc + pc_t'(FETCH_BYTES);
      compare_value("fetch_pc", fetch_pc, exp_pc);
    end
    fetch_ready = 1'b0;
    finish_test("sequential fetch");

    send_update(32'h0000_2050, 32'h0000_3000, 12'h000, 1'b0, 0);
    send_update(32'h0000_2050, 32'h0000_3000, 12'h000, 1'b1, 2);
    finish_test("handshake and redirect");

    // install branch, one flip makes it predicted taken
    send_update(P_BR, T_BR, H_BR, 1'b1, 0);
    visit_branch();
    accept_fetch();
    compare_value("fetch_pc", fetch_pc, T_BR);
    compare_value("fetch_hist", 32'(fetch_hist), 32'({H_BR[HIST_W-2:0], 1'b1}));
    finish_test("btb install");

    // second flip, back to not taken
    send_update(P_BR, T_BR, H_BR, 1'b1, 0);
    visit_branch();
    accept_fetch();
    compare_value("fetch_pc", fetch_pc, P_BR + pc_t'(FETCH_BYTES));
    compare_value("fetch_hist", 32'(fetch_hist), 32'({H_BR[HIST_W-2:0], 1'b0}));
    finish_test("prediction flip back");

    repeat (2) @(negedge clk);
    total_err = errors + int'(DUT.u_fe_assert.fail_cnt);
    $display("tests: %0d, checks: %0d, check errors: %0d, assertion failures: %0d",
             tests, checks, errors, DUT.u_fe_assert.fail_cnt);
    if (total_err == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
